// File: Makefile
# Verilator build and run for the decode stage testbench

LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f files.f --top-module tb_decode_stage

run: build
	./obj_dir/Vtb_decode_stage | tee $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then exit 1; fi
	@grep -q "ALL TESTS PASSED" $(LOG)

lint:
	verilator --lint-only --timing rtl/decode_pkg.sv rtl/fwd_if.sv rtl/inst_decoder.sv \
		rtl/operand_forward.sv rtl/branch_resolve.sv rtl/decode_out_reg.sv \
		rtl/decode_stage.sv --top-module decode_stage

clean:
	rm -rf obj_dir $(LOG)

// File: files.f
rtl/decode_pkg.sv
rtl/fwd_if.sv
rtl/inst_decoder.sv
rtl/operand_forward.sv
rtl/branch_resolve.sv
rtl/decode_out_reg.sv
rtl/decode_stage.sv
sim/tb_decode_stage.sv

// File: rtl/branch_resolve.sv
// Branch condition evaluation and redirect target selection.
// pc_i must be at least 2-byte aligned, PHT_INDEX_W + 2 must fit in XLEN.
// Redirect outputs are not qualified by valid here.
`timescale 1ns/1ps
`default_nettype none

module branch_resolve #(
  parameter int PHT_INDEX_W = 4
) (
  input  decode_pkg::decoded_t        dec_i,
  input  logic [decode_pkg::XLEN-1:0] pc_i,
  input  logic [decode_pkg::XLEN-1:0] rs1_val_i,
  input  logic [decode_pkg::XLEN-1:0] rs2_val_i,
  input  logic                        predict_taken_i,
  output logic                        redirect_o,
  output logic [decode_pkg::XLEN-1:0] redirect_pc_o,
  output logic                        pht_ena_o,
  output logic [PHT_INDEX_W-1:0]      pht_index_o,
  output logic                        pht_taken_o
);
  import decode_pkg::*;

  logic            is_branch;
  logic            is_jalr;
  logic            taken;
  logic            mispredict;
  logic [XLEN-1:0] branch_pc;
  logic [XLEN-1:0] jalr_sum;

  assign is_branch = (dec_i.inst_class == BRANCH);
  assign is_jalr   = (dec_i.inst_class == JALR);

  always_comb begin
    case (dec_i.funct3)
      3'b000:  taken = (rs1_val_i == rs2_val_i);
      3'b001:  taken = (rs1_val_i != rs2_val_i);
      3'b100:  taken = ($signed(rs1_val_i) < $signed(rs2_val_i));
      3'b101:  taken = ($signed(rs1_val_i) >= $signed(rs2_val_i));
      3'b110:  taken = (rs1_val_i < rs2_val_i);
      3'b111:  taken = (rs1_val_i >= rs2_val_i);
      default: taken = 1'b0;
    endcase
  end

  assign mispredict = is_branch && (taken != predict_taken_i);

  // fetch already went the predicted way, so take the other path
  assign branch_pc = predict_taken_i ? (pc_i + XLEN'(4)) : (pc_i + dec_i.imm_b);
  assign jalr_sum  = rs1_val_i + dec_i.imm_i;

  assign redirect_o    = mispredict || is_jalr;
  assign redirect_pc_o = is_jalr    ? {jalr_sum[XLEN-1:1], 1'b0} :
                         mispredict ? branch_pc : '0;

  assign pht_ena_o   = is_branch;
  assign pht_index_o = pc_i[PHT_INDEX_W+1:2];
  assign pht_taken_o = is_branch && taken;

  // odd target means a misaligned pc came in from fetch
  always_comb begin
    assert final (!redirect_o || !redirect_pc_o[0]);
  end

endmodule

`default_nettype wire

// File: rtl/decode_out_reg.sv
// Decode/execute register with operand and memory address selection.
// One cycle latency, no stall or flush. Payload outputs hold their last
// value while inst_valid_i is low, enables drop at the next edge.
`timescale 1ns/1ps
`default_nettype none

module decode_out_reg #(
  parameter int PHT_INDEX_W = 4
) (
  input  logic                              clk_i,
  input  logic                              arst_n_i,
  input  logic                              inst_valid_i,
  input  logic [decode_pkg::XLEN-1:0]       pc_i,
  input  decode_pkg::decoded_t              dec_i,
  input  logic [decode_pkg::XLEN-1:0]       rs1_val_i,
  input  logic [decode_pkg::XLEN-1:0]       rs2_val_i,
  input  logic                              redirect_i,
  input  logic [decode_pkg::XLEN-1:0]       redirect_pc_i,
  input  logic                              pht_ena_i,
  input  logic [PHT_INDEX_W-1:0]            pht_index_i,
  input  logic                              pht_taken_i,
  output logic                              valid_o,
  output decode_pkg::inst_class_e           class_o,
  output logic [2:0]                        funct3_o,
  output logic                              alt_o,
  output logic [decode_pkg::XLEN-1:0]       op1_o,
  output logic [decode_pkg::XLEN-1:0]       op2_o,
  output logic                              rd_w_ena_o,
  output logic [decode_pkg::REG_ADDR_W-1:0] rd_w_addr_o,
  output logic [decode_pkg::XLEN-1:0]       pc_o,
  output logic [decode_pkg::XLEN-1:0]       mem_addr_o,
  output logic [2:0]                        mem_sel_o,
  output logic                              jump_pc_ena_o,
  output logic [decode_pkg::XLEN-1:0]       jump_pc_o,
  output logic                              pht_update_ena_o,
  output logic [PHT_INDEX_W-1:0]            pht_index_o,
  output logic                              pht_taken_o
);
  import decode_pkg::*;

  logic [XLEN-1:0] op1;
  logic [XLEN-1:0] op2;
  logic [XLEN-1:0] mem_addr;
  logic [2:0]      mem_sel;

  always_comb begin
    op1      = '0;
    op2      = '0;
    mem_addr = '0;
    mem_sel  = '0;
    if (dec_i.rs1_read) begin
      op1 = rs1_val_i;
    end else if (dec_i.inst_class inside {AUIPC, JAL}) begin
      op1 = pc_i;
    end
    if (dec_i.rs2_read) begin
      op2 = rs2_val_i;
    end else if (dec_i.inst_class inside {ALU_IMM, ALU_IMMW, LOAD}) begin
      op2 = dec_i.imm_i;
    end else if (dec_i.inst_class inside {LUI, AUIPC}) begin
      op2 = dec_i.imm_u;
    end else if (dec_i.inst_class inside {JAL, JALR}) begin
      // link value is formed in execute
      op2 = pc_i;
    end
    if (dec_i.inst_class == LOAD) begin
      mem_addr = rs1_val_i + dec_i.imm_i;
      mem_sel  = dec_i.funct3;
    end else if (dec_i.inst_class == STORE) begin
      mem_addr = rs1_val_i + dec_i.imm_s;
      mem_sel  = dec_i.funct3;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_o          <= 1'b0;
      rd_w_ena_o       <= 1'b0;
      jump_pc_ena_o    <= 1'b0;
      pht_update_ena_o <= 1'b0;
    end else begin
      valid_o          <= inst_valid_i;
      rd_w_ena_o       <= inst_valid_i && dec_i.rd_w_ena;
      jump_pc_ena_o    <= inst_valid_i && redirect_i;
      pht_update_ena_o <= inst_valid_i && pht_ena_i;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      class_o     <= ILLEGAL;
      funct3_o    <= '0;
      alt_o       <= 1'b0;
      op1_o       <= '0;
      op2_o       <= '0;
      rd_w_addr_o <= '0;
      pc_o        <= '0;
      mem_addr_o  <= '0;
      mem_sel_o   <= '0;
      jump_pc_o   <= '0;
      pht_index_o <= '0;
      pht_taken_o <= 1'b0;
    end else if (inst_valid_i) begin
      class_o     <= dec_i.inst_class;
      funct3_o    <= dec_i.funct3;
      alt_o       <= dec_i.alt;
      op1_o       <= op1;
      op2_o       <= op2;
      rd_w_addr_o <= dec_i.rd_addr;
      pc_o        <= pc_i;
      mem_addr_o  <= mem_addr;
      mem_sel_o   <= mem_sel;
      jump_pc_o   <= redirect_pc_i;
      pht_index_o <= pht_index_i;
      pht_taken_o <= pht_taken_i;
    end
  end

  // fetch must only see a redirect for a valid branch or jalr
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
                   jump_pc_ena_o |-> valid_o && (class_o inside {BRANCH, JALR}));

endmodule

`default_nettype wire

// File: rtl/decode_pkg.sv
// Shared widths and types for the RV64I decode stage.
// Only the base integer classes are known. CSR, fence.i and M-extension
// encodings decode as ILLEGAL.
`default_nettype none

package decode_pkg;

  localparam int XLEN       = 64;
  localparam int REG_ADDR_W = 5;

  // ILLEGAL must stay zero, reset values rely on it
  typedef enum logic [3:0] {
    ILLEGAL  = 4'd0,
    ALU_REG  = 4'd1,
    ALU_IMM  = 4'd2,
    ALU_REGW = 4'd3,
    ALU_IMMW = 4'd4,
    BRANCH   = 4'd5,
    LOAD     = 4'd6,
    STORE    = 4'd7,
    LUI      = 4'd8,
    AUIPC    = 4'd9,
    JAL      = 4'd10,
    JALR     = 4'd11
  } inst_class_e;

  typedef struct packed {
    inst_class_e           inst_class;
    logic [2:0]            funct3;
    // funct7[5] for register forms, imm[10] for shifts
    logic                  alt;
    logic                  rs1_read;
    logic [REG_ADDR_W-1:0] rs1_addr;
    logic                  rs2_read;
    logic [REG_ADDR_W-1:0] rs2_addr;
    logic                  rd_w_ena;
    logic [REG_ADDR_W-1:0] rd_addr;
    // all sign-extended to XLEN
    logic [XLEN-1:0]       imm_i;
    logic [XLEN-1:0]       imm_s;
    logic [XLEN-1:0]       imm_b;
    // raw 20-bit field, not shifted into place
    logic [XLEN-1:0]       imm_u;
  } decoded_t;

endpackage

`default_nettype wire

// File: rtl/decode_stage.sv
// RV64I decode stage top level. Read addresses are combinational from
// inst_i, everything else is registered one cycle after acceptance.
// No back-pressure, one instruction may be accepted per cycle.
`timescale 1ns/1ps
`default_nettype none

module decode_stage #(
  parameter int PHT_INDEX_W = 4
) (
  input  logic                              clk_i,
  input  logic                              arst_n_i,
  input  logic [31:0]                       inst_i,
  input  logic                              inst_valid_i,
  input  logic [decode_pkg::XLEN-1:0]       pc_i,
  input  logic                              predict_taken_i,
  input  logic [decode_pkg::XLEN-1:0]       rs1_data_i,
  input  logic [decode_pkg::XLEN-1:0]       rs2_data_i,
  input  logic [decode_pkg::XLEN-1:0]       alu1_pc_i,
  input  logic [decode_pkg::REG_ADDR_W-1:0] alu1_rd_addr_i,
  input  logic [decode_pkg::XLEN-1:0]       alu1_rd_data_i,
  input  logic                              alu1_rd_ena_i,
  input  logic [decode_pkg::XLEN-1:0]       alu2_pc_i,
  input  logic [decode_pkg::REG_ADDR_W-1:0] alu2_rd_addr_i,
  input  logic [decode_pkg::XLEN-1:0]       alu2_rd_data_i,
  input  logic                              alu2_rd_ena_i,
  input  logic [decode_pkg::XLEN-1:0]       mem_pc_i,
  input  logic [decode_pkg::REG_ADDR_W-1:0] mem_rd_addr_i,
  input  logic [decode_pkg::XLEN-1:0]       mem_rd_data_i,
  input  logic                              mem_rd_ena_i,
  output logic [decode_pkg::REG_ADDR_W-1:0] rs1_addr_o,
  output logic                              rs1_read_o,
  output logic [decode_pkg::REG_ADDR_W-1:0] rs2_addr_o,
  output logic                              rs2_read_o,
  output logic                              valid_o,
  output decode_pkg::inst_class_e           class_o,
  output logic [2:0]                        funct3_o,
  output logic                              alt_o,
  output logic [decode_pkg::XLEN-1:0]       op1_o,
  output logic [decode_pkg::XLEN-1:0]       op2_o,
  output logic                              rd_w_ena_o,
  output logic [decode_pkg::REG_ADDR_W-1:0] rd_w_addr_o,
  output logic [decode_pkg::XLEN-1:0]       pc_o,
  output logic [decode_pkg::XLEN-1:0]       mem_addr_o,
  output logic [2:0]                        mem_sel_o,
  output logic                              jump_pc_ena_o,
  output logic [decode_pkg::XLEN-1:0]       jump_pc_o,
  output logic                              pht_update_ena_o,
  output logic [PHT_INDEX_W-1:0]            pht_index_o,
  output logic                              pht_taken_o
);
  import decode_pkg::*;

  decoded_t               dec;
  logic [XLEN-1:0]        rs1_val;
  logic [XLEN-1:0]        rs2_val;
  logic                   redirect;
  logic [XLEN-1:0]        redirect_pc;
  logic                   pht_ena;
  logic [PHT_INDEX_W-1:0] pht_index;
  logic                   pht_taken;

  fwd_if alu1_if ();
  fwd_if alu2_if ();
  fwd_if mem_if ();

  assign alu1_if.pc      = alu1_pc_i;
  assign alu1_if.rd_addr = alu1_rd_addr_i;
  assign alu1_if.rd_data = alu1_rd_data_i;
  assign alu1_if.rd_ena  = alu1_rd_ena_i;
  assign alu2_if.pc      = alu2_pc_i;
  assign alu2_if.rd_addr = alu2_rd_addr_i;
  assign alu2_if.rd_data = alu2_rd_data_i;
  assign alu2_if.rd_ena  = alu2_rd_ena_i;
  assign mem_if.pc       = mem_pc_i;
  assign mem_if.rd_addr  = mem_rd_addr_i;
  assign mem_if.rd_data  = mem_rd_data_i;
  assign mem_if.rd_ena   = mem_rd_ena_i;

  inst_decoder u_decoder (
    .inst_i       (inst_i),
    .inst_valid_i (inst_valid_i),
    .dec_o        (dec),
    .rs1_addr_o   (rs1_addr_o),
    .rs1_read_o   (rs1_read_o),
    .rs2_addr_o   (rs2_addr_o),
    .rs2_read_o   (rs2_read_o)
  );

  operand_forward u_fwd_rs1 (
    .src_addr_i (rs1_addr_o),
    .src_read_i (rs1_read_o),
    .reg_data_i (rs1_data_i),
    .alu1_if    (alu1_if),
    .alu2_if    (alu2_if),
    .mem_if     (mem_if),
    .value_o    (rs1_val)
  );

  operand_forward u_fwd_rs2 (
    .src_addr_i (rs2_addr_o),
    .src_read_i (rs2_read_o),
    .reg_data_i (rs2_data_i),
    .alu1_if    (alu1_if),
    .alu2_if    (alu2_if),
    .mem_if     (mem_if),
    .value_o    (rs2_val)
  );

  branch_resolve #(
    .PHT_INDEX_W (PHT_INDEX_W)
  ) u_branch (
    .dec_i           (dec),
    .pc_i            (pc_i),
    .rs1_val_i       (rs1_val),
    .rs2_val_i       (rs2_val),
    .predict_taken_i (predict_taken_i),
    .redirect_o      (redirect),
    .redirect_pc_o   (redirect_pc),
    .pht_ena_o       (pht_ena),
    .pht_index_o     (pht_index),
    .pht_taken_o     (pht_taken)
  );

  decode_out_reg #(
    .PHT_INDEX_W (PHT_INDEX_W)
  ) u_out_reg (
    .clk_i            (clk_i),
    .arst_n_i         (arst_n_i),
    .inst_valid_i     (inst_valid_i),
    .pc_i             (pc_i),
    .dec_i            (dec),
    .rs1_val_i        (rs1_val),
    .rs2_val_i        (rs2_val),
    .redirect_i       (redirect),
    .redirect_pc_i    (redirect_pc),
    .pht_ena_i        (pht_ena),
    .pht_index_i      (pht_index),
    .pht_taken_i      (pht_taken),
    .valid_o          (valid_o),
    .class_o          (class_o),
    .funct3_o         (funct3_o),
    .alt_o            (alt_o),
    .op1_o            (op1_o),
    .op2_o            (op2_o),
    .rd_w_ena_o       (rd_w_ena_o),
    .rd_w_addr_o      (rd_w_addr_o),
    .pc_o             (pc_o),
    .mem_addr_o       (mem_addr_o),
    .mem_sel_o        (mem_sel_o),
    .jump_pc_ena_o    (jump_pc_ena_o),
    .jump_pc_o        (jump_pc_o),
    .pht_update_ena_o (pht_update_ena_o),
    .pht_index_o      (pht_index_o),
    .pht_taken_o      (pht_taken_o)
  );

endmodule

`default_nettype wire

// File: rtl/fwd_if.sv
// One forwarding producer. No handshake, rd_ena is a level that
// qualifies the other fields in the same cycle.
`timescale 1ns/1ps
`default_nettype none

interface fwd_if;
  import decode_pkg::*;

  logic [XLEN-1:0]       pc;
  logic [REG_ADDR_W-1:0] rd_addr;
  logic [XLEN-1:0]       rd_data;
  logic                  rd_ena;

  // driving pipeline stage
  modport src  (output pc, rd_addr, rd_data, rd_ena);
  // operand forwarding logic
  modport sink (input pc, rd_addr, rd_data, rd_ena);

endinterface

`default_nettype wire

// File: rtl/inst_decoder.sv
// Combinational RV64I field extraction and classification.
// The class comes from opcode bits only, funct3/funct7 are not checked.
// Read flags and read addresses are forced low while inst_valid_i is low.
`timescale 1ns/1ps
`default_nettype none

module inst_decoder (
  input  logic [31:0]                       inst_i,
  input  logic                              inst_valid_i,
  output decode_pkg::decoded_t              dec_o,
  output logic [decode_pkg::REG_ADDR_W-1:0] rs1_addr_o,
  output logic                              rs1_read_o,
  output logic [decode_pkg::REG_ADDR_W-1:0] rs2_addr_o,
  output logic                              rs2_read_o
);
  import decode_pkg::*;

  // major opcodes, bits 6:2
  localparam logic [4:0] OPC_LOAD   = 5'b00000;
  localparam logic [4:0] OPC_OP_IMM = 5'b00100;
  localparam logic [4:0] OPC_AUIPC  = 5'b00101;
  localparam logic [4:0] OPC_IMM_W  = 5'b00110;
  localparam logic [4:0] OPC_STORE  = 5'b01000;
  localparam logic [4:0] OPC_OP     = 5'b01100;
  localparam logic [4:0] OPC_LUI    = 5'b01101;
  localparam logic [4:0] OPC_OP_W   = 5'b01110;
  localparam logic [4:0] OPC_BRANCH = 5'b11000;
  localparam logic [4:0] OPC_JALR   = 5'b11001;
  localparam logic [4:0] OPC_JAL    = 5'b11011;

  logic [6:0]  opcode;
  logic [2:0]  funct3;
  inst_class_e cls;
  logic        alt;
  logic        rs1_read;
  logic        rs2_read;
  logic        rd_w_ena;

  assign opcode = inst_i[6:0];
  assign funct3 = inst_i[14:12];

  always_comb begin
    cls = ILLEGAL;
    // 16-bit encodings never match
    if (opcode[1:0] == 2'b11) begin
      case (opcode[6:2])
        OPC_LOAD:   cls = LOAD;
        OPC_OP_IMM: cls = ALU_IMM;
        OPC_AUIPC:  cls = AUIPC;
        OPC_IMM_W:  cls = ALU_IMMW;
        OPC_STORE:  cls = STORE;
        OPC_OP:     cls = ALU_REG;
        OPC_LUI:    cls = LUI;
        OPC_OP_W:   cls = ALU_REGW;
        OPC_BRANCH: cls = BRANCH;
        OPC_JALR:   cls = JALR;
        OPC_JAL:    cls = JAL;
        default:    cls = ILLEGAL;
      endcase
    end
  end

  assign rs1_read = inst_valid_i && !(cls inside {ILLEGAL, LUI, AUIPC, JAL});
  assign rs2_read = inst_valid_i && (cls inside {ALU_REG, ALU_REGW, BRANCH, STORE});
  assign rd_w_ena = !(cls inside {ILLEGAL, BRANCH, STORE});

  // inst[30] is sub/sra for register forms, srai/sraiw for shifts
  assign alt = ((cls inside {ALU_REG, ALU_REGW}) ||
                ((cls inside {ALU_IMM, ALU_IMMW}) && (funct3 == 3'b101))) ? inst_i[30] : 1'b0;

  always_comb begin
    dec_o.inst_class = cls;
    dec_o.funct3     = funct3;
    dec_o.alt        = alt;
    dec_o.rs1_read   = rs1_read;
    dec_o.rs1_addr   = rs1_read ? inst_i[19:15] : '0;
    dec_o.rs2_read   = rs2_read;
    dec_o.rs2_addr   = rs2_read ? inst_i[24:20] : '0;
    dec_o.rd_w_ena   = rd_w_ena;
    dec_o.rd_addr    = rd_w_ena ? inst_i[11:7] : '0;
    dec_o.imm_i      = {{(XLEN-12){inst_i[31]}}, inst_i[31:20]};
    dec_o.imm_s      = {{(XLEN-12){inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
    dec_o.imm_b      = {{(XLEN-13){inst_i[31]}}, inst_i[31], inst_i[7],
                        inst_i[30:25], inst_i[11:8], 1'b0};
    dec_o.imm_u      = {{(XLEN-20){inst_i[31]}}, inst_i[31:12]};
  end

  assign rs1_read_o = dec_o.rs1_read;
  assign rs1_addr_o = dec_o.rs1_addr;
  assign rs2_read_o = dec_o.rs2_read;
  assign rs2_addr_o = dec_o.rs2_addr;

endmodule

`default_nettype wire

// File: rtl/operand_forward.sv
// Forwarding mux for one source register.
// Youngest producer is the one with the largest pc, so pc values of
// in-flight instructions must be unique and must not wrap.
// Equal pc ties resolve to alu1, then alu2, then mem.
`timescale 1ns/1ps
`default_nettype none

module operand_forward (
  input  logic [decode_pkg::REG_ADDR_W-1:0] src_addr_i,
  input  logic                              src_read_i,
  input  logic [decode_pkg::XLEN-1:0]       reg_data_i,
  fwd_if.sink                               alu1_if,
  fwd_if.sink                               alu2_if,
  fwd_if.sink                               mem_if,
  output logic [decode_pkg::XLEN-1:0]       value_o
);
  import decode_pkg::*;

  logic hit_alu1;
  logic hit_alu2;
  logic hit_mem;
  logic sel_alu1;
  logic sel_alu2;
  logic sel_mem;

  // x0 is never forwarded
  assign hit_alu1 = alu1_if.rd_ena && (alu1_if.rd_addr == src_addr_i) && (src_addr_i != '0);
  assign hit_alu2 = alu2_if.rd_ena && (alu2_if.rd_addr == src_addr_i) && (src_addr_i != '0);
  assign hit_mem  = mem_if.rd_ena && (mem_if.rd_addr == src_addr_i) && (src_addr_i != '0);

  assign sel_alu1 = hit_alu1 &&
                    (!hit_alu2 || (alu1_if.pc >= alu2_if.pc)) &&
                    (!hit_mem || (alu1_if.pc >= mem_if.pc));
  assign sel_alu2 = hit_alu2 && !sel_alu1 &&
                    (!hit_mem || (alu2_if.pc >= mem_if.pc));
  assign sel_mem  = hit_mem && !sel_alu1 && !sel_alu2;

  always_comb begin
    if (!src_read_i) begin
      value_o = '0;
    end else if (sel_alu1) begin
      value_o = alu1_if.rd_data;
    end else if (sel_alu2) begin
      value_o = alu2_if.rd_data;
    end else if (sel_mem) begin
      value_o = mem_if.rd_data;
    end else begin
      value_o = reg_data_i;
    end
  end

endmodule

`default_nettype wire

// File: sim/decode_testdata.txt
# stim: grp inst pc pred rs1_data rs2_data {alu1,alu2,mem: pc rd_addr rd_data rd_ena}
# exp:  rs1a rs1r rs2a rs2r class f3 alt op1 op2 rdw rda maddr msel jena jpc phte phti phtt
# group 2: alu, w-forms, lui, auipc, jal
2 402081b3 100 0 11 22 0 0 0 0 0 0 0 0 0 0 0 0
1 1 2 1 1 0 1 11 22 1 3 0 0 0 0 0 0 0
2 ff020293 104 0 100 0 0 0 0 0 0 0 0 0 0 0 0 0
4 1 0 0 2 0 0 100 fffffffffffffff0 1 5 0 0 0 0 0 0 0
2 4033d31b 108 0 80 0 0 0 0 0 0 0 0 0 0 0 0 0
7 1 0 0 4 5 1 80 403 1 6 0 0 0 0 0 0 0
2 00a4843b 10c 0 5 6 0 0 0 0 0 0 0 0 0 0 0 0
9 1 a 1 3 0 0 5 6 1 8 0 0 0 0 0 0 0
2 123455b7 110 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 8 5 0 0 12345 1 b 0 0 0 0 0 0 0
2 fffff617 114 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 9 7 0 114 ffffffffffffffff 1 c 0 0 0 0 0 0 0
2 008000ef 118 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 a 0 0 118 118 1 1 0 0 0 0 0 0 0
# group 3: forwarding on add x3, x1, x2
3 002081b3 200 0 11 22 50 1 aa 1 0 0 0 0 0 0 0 0
1 1 2 1 1 0 0 aa 22 1 3 0 0 0 0 0 0 0
3 002081b3 200 0 11 22 0 0 0 0 60 2 bb 1 0 0 0 0
1 1 2 1 1 0 0 11 bb 1 3 0 0 0 0 0 0 0
3 002081b3 200 0 11 22 0 0 0 0 0 0 0 0 70 1 cc 1
1 1 2 1 1 0 0 cc 22 1 3 0 0 0 0 0 0 0
3 002081b3 200 0 11 22 40 1 a1 1 48 1 a2 1 44 1 a3 1
1 1 2 1 1 0 0 a2 22 1 3 0 0 0 0 0 0 0
3 002081b3 200 0 11 22 40 2 b1 1 30 1 a2 1 50 2 b3 1
1 1 2 1 1 0 0 a2 b3 1 3 0 0 0 0 0 0 0
3 002081b3 200 0 11 22 40 1 1 1 40 1 2 1 40 1 3 1
1 1 2 1 1 0 0 1 22 1 3 0 0 0 0 0 0 0
3 002081b3 200 0 11 22 0 0 0 0 40 2 2 1 40 2 3 1
1 1 2 1 1 0 0 11 2 1 3 0 0 0 0 0 0 0
3 002001b3 200 0 77 22 40 0 ee 1 44 0 ef 1 0 0 0 0
0 1 2 1 1 0 0 77 22 1 3 0 0 0 0 0 0 0
# group 4: branches at pc 324, offset +16
4 00208863 324 0 5 5 0 0 0 0 0 0 0 0 0 0 0 0
1 1 2 1 5 0 0 5 5 0 0 0 0 1 334 1 9 1
4 00208863 324 1 5 5 0 0 0 0 0 0 0 0 0 0 0 0
1 1 2 1 5 0 0 5 5 0 0 0 0 0 0 1 9 1
4 00209863 324 0 5 5 0 0 0 0 0 0 0 0 0 0 0 0
1 1 2 1 5 1 0 5 5 0 0 0 0 0 0 1 9 0
4 00209863 324 1 5 5 0 0 0 0 0 0 0 0 0 0 0 0
1 1 2 1 5 1 0 5 5 0 0 0 0 1 328 1 9 0
4 0020c863 324 0 ffffffffffffffff 1 0 0 0 0 0 0 0 0 0 0 0 0
1 1 2 1 5 4 0 ffffffffffffffff 1 0 0 0 0 1 334 1 9 1
4 0020c863 324 1 ffffffffffffffff 1 0 0 0 0 0 0 0 0 0 0 0 0
1 1 2 1 5 4 0 ffffffffffffffff 1 0 0 0 0 0 0 1 9 1
4 0020d863 324 0 ffffffffffffffff 1 0 0 0 0 0 0 0 0 0 0 0 0
1 1 2 1 5 5 0 ffffffffffffffff 1 0 0 0 0 0 0 1 9 0
4 0020d863 324 1 ffffffffffffffff 1 0 0 0 0 0 0 0 0 0 0 0 0
1 1 2 1 5 5 0 ffffffffffffffff 1 0 0 0 0 1 328 1 9 0
4 0020e863 324 0 ffffffffffffffff 1 0 0 0 0 0 0 0 0 0 0 0 0
1 1 2 1 5 6 0 ffffffffffffffff 1 0 0 0 0 0 0 1 9 0
4 0020e863 324 1 ffffffffffffffff 1 0 0 0 0 0 0 0 0 0 0 0 0
1 1 2 1 5 6 0 ffffffffffffffff 1 0 0 0 0 1 328 1 9 0
4 0020f863 324 0 ffffffffffffffff 1 0 0 0 0 0 0 0 0 0 0 0 0
1 1 2 1 5 7 0 ffffffffffffffff 1 0 0 0 0 1 334 1 9 1
4 0020f863 324 1 ffffffffffffffff 1 0 0 0 0 0 0 0 0 0 0 0 0
1 1 2 1 5 7 0 ffffffffffffffff 1 0 0 0 0 0 0 1 9 1
# group 5: jalr x1, 5(x6) with forwarded rs1, odd sum
5 005300e7 400 0 9 0 3f0 6 1000 1 0 0 0 0 0 0 0 0
6 1 0 0 b 0 0 1000 400 1 1 0 0 1 1004 0 0 0
# group 6: ld x7, -8(x5) and sw x8, 20(x9)
6 ff82b383 500 0 2000 0 0 0 0 0 0 0 0 0 0 0 0 0
5 1 0 0 6 3 0 2000 fffffffffffffff8 1 7 1ff8 3 0 0 0 0 0
6 0084aa23 504 0 3000 55 0 0 0 0 0 0 0 0 0 0 0 0
9 1 8 1 7 2 0 3000 55 0 0 3014 2 0 0 0 0 0

// File: sim/tb_decode_stage.sv
// Testbench for decode_stage, vectors come from sim/decode_testdata.txt.
// Each vector is a stimulus line followed by an expected-value line.
// Run from the project root so the data file path resolves.
`timescale 1ns/1ps
`default_nettype none

module tb_decode_stage;
  import decode_pkg::*;

  localparam int MAX_VEC = 64;
  localparam int NTOK    = 18;

  logic                  clk_i;
  logic                  arst_n_i;
  logic [31:0]           inst_i;
  logic                  inst_valid_i;
  logic [XLEN-1:0]       pc_i;
  logic                  predict_taken_i;
  logic [XLEN-1:0]       rs1_data_i;
  logic [XLEN-1:0]       rs2_data_i;
  logic [XLEN-1:0]       alu1_pc_i;
  logic [REG_ADDR_W-1:0] alu1_rd_addr_i;
  logic [XLEN-1:0]       alu1_rd_data_i;
  logic                  alu1_rd_ena_i;
  logic [XLEN-1:0]       alu2_pc_i;
  logic [REG_ADDR_W-1:0] alu2_rd_addr_i;
  logic [XLEN-1:0]       alu2_rd_data_i;
  logic                  alu2_rd_ena_i;
  logic [XLEN-1:0]       mem_pc_i;
  logic [REG_ADDR_W-1:0] mem_rd_addr_i;
  logic [XLEN-1:0]       mem_rd_data_i;
  logic                  mem_rd_ena_i;
  logic [REG_ADDR_W-1:0] rs1_addr_o;
  logic                  rs1_read_o;
  logic [REG_ADDR_W-1:0] rs2_addr_o;
  logic                  rs2_read_o;
  logic                  valid_o;
  inst_class_e           class_o;
  logic [2:0]            funct3_o;
  logic                  alt_o;
  logic [XLEN-1:0]       op1_o;
  logic [XLEN-1:0]       op2_o;
  logic                  rd_w_ena_o;
  logic [REG_ADDR_W-1:0] rd_w_addr_o;
  logic [XLEN-1:0]       pc_o;
  logic [XLEN-1:0]       mem_addr_o;
  logic [2:0]            mem_sel_o;
  logic                  jump_pc_ena_o;
  logic [XLEN-1:0]       jump_pc_o;
  logic                  pht_update_ena_o;
  logic [3:0]            pht_index_o;
  logic                  pht_taken_o;

  logic [63:0] stim [MAX_VEC][NTOK];
  logic [63:0] expv [MAX_VEC][NTOK];
  int          n_vec;
  int          cur_vec;
  int          errors;
  int          grp_errs;
  int          grp_cnt;
  int          cur_grp;

  decode_stage #(
    .PHT_INDEX_W (4)
  ) decode_stage_inst (
    .clk_i            (clk_i),
    .arst_n_i         (arst_n_i),
    .inst_i           (inst_i),
    .inst_valid_i     (inst_valid_i),
    .pc_i             (pc_i),
    .predict_taken_i  (predict_taken_i),
    .rs1_data_i       (rs1_data_i),
    .rs2_data_i       (rs2_data_i),
    .alu1_pc_i        (alu1_pc_i),
    .alu1_rd_addr_i   (alu1_rd_addr_i),
    .alu1_rd_data_i   (alu1_rd_data_i),
    .alu1_rd_ena_i    (alu1_rd_ena_i),
    .alu2_pc_i        (alu2_pc_i),
    .alu2_rd_addr_i   (alu2_rd_addr_i),
    .alu2_rd_data_i   (alu2_rd_data_i),
    .alu2_rd_ena_i    (alu2_rd_ena_i),
    .mem_pc_i         (mem_pc_i),
    .mem_rd_addr_i    (mem_rd_addr_i),
    .mem_rd_data_i    (mem_rd_data_i),
    .mem_rd_ena_i     (mem_rd_ena_i),
    .rs1_addr_o       (rs1_addr_o),
    .rs1_read_o       (rs1_read_o),
    .rs2_addr_o       (rs2_addr_o),
    .rs2_read_o       (rs2_read_o),
    .valid_o          (valid_o),
    .class_o          (class_o),
    .funct3_o         (funct3_o),
    .alt_o            (alt_o),
    .op1_o            (op1_o),
    .op2_o            (op2_o),
    .rd_w_ena_o       (rd_w_ena_o),
    .rd_w_addr_o      (rd_w_addr_o),
    .pc_o             (pc_o),
    .mem_addr_o       (mem_addr_o),
    .mem_sel_o        (mem_sel_o),
    .jump_pc_ena_o    (jump_pc_ena_o),
    .jump_pc_o        (jump_pc_o),
    .pht_update_ena_o (pht_update_ena_o),
    .pht_index_o      (pht_index_o),
    .pht_taken_o      (pht_taken_o)
  );

  always #10 clk_i = ~clk_i;

  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("** Error vector %0d: %s = %h, expected %h", cur_vec, name, got, exp);
      errors++;
      grp_errs++;
    end
  endtask

  task automatic load_vectors();
    int          fd;
    int          n;
    int          half;
    string       line;
    logic [63:0] t [NTOK];
    fd = $fopen("sim/decode_testdata.txt", "r");
    if (fd == 0) begin
      $display("could not open the test data file");
      errors++;
      return;
    end
    half = 0;
    while ($fgets(line, fd) != 0 && n_vec < MAX_VEC) begin
      if (line.len() < 2 || line.getc(0) == "#") begin
        continue;
      end
      n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                  t[0], t[1], t[2], t[3], t[4], t[5], t[6], t[7], t[8],
                  t[9], t[10], t[11], t[12], t[13], t[14], t[15], t[16], t[17]);
      if (n != NTOK) begin
        $display("malformed line in test data: %s", line);
        errors++;
        continue;
      end
      if (half == 0) begin
        stim[n_vec] = t;
      end else begin
        expv[n_vec] = t;
        n_vec++;
      end
      half = 1 - half;
    end
    $fclose(fd);
  endtask

  // all enables low and all payloads zero
  task automatic check_idle_outputs();
    check_val("valid_o", 64'(valid_o), 64'd0);
    check_val("rd_w_ena_o", 64'(rd_w_ena_o), 64'd0);
    check_val("jump_pc_ena_o", 64'(jump_pc_ena_o), 64'd0);
    check_val("pht_update_ena_o", 64'(pht_update_ena_o), 64'd0);
    check_val("class_o", 64'(class_o), 64'd0);
    check_val("funct3_o", 64'(funct3_o), 64'd0);
    check_val("alt_o", 64'(alt_o), 64'd0);
    check_val("op1_o", op1_o, 64'd0);
    check_val("op2_o", op2_o, 64'd0);
    check_val("pc_o", pc_o, 64'd0);
    check_val("mem_addr_o", mem_addr_o, 64'd0);
    check_val("mem_sel_o", 64'(mem_sel_o), 64'd0);
    check_val("jump_pc_o", jump_pc_o, 64'd0);
    check_val("rd_w_addr_o", 64'(rd_w_addr_o), 64'd0);
    check_val("pht_index_o", 64'(pht_index_o), 64'd0);
    check_val("pht_taken_o", 64'(pht_taken_o), 64'd0);
  endtask

  task automatic apply_vector(input int i);
    inst_i          = stim[i][1][31:0];
    inst_valid_i    = 1'b1;
    pc_i            = stim[i][2];
    predict_taken_i = stim[i][3][0];
    rs1_data_i      = stim[i][4];
    rs2_data_i      = stim[i][5];
    alu1_pc_i       = stim[i][6];
    alu1_rd_addr_i  = stim[i][7][4:0];
    alu1_rd_data_i  = stim[i][8];
    alu1_rd_ena_i   = stim[i][9][0];
    alu2_pc_i       = stim[i][10];
    alu2_rd_addr_i  = stim[i][11][4:0];
    alu2_rd_data_i  = stim[i][12];
    alu2_rd_ena_i   = stim[i][13][0];
    mem_pc_i        = stim[i][14];
    mem_rd_addr_i   = stim[i][15][4:0];
    mem_rd_data_i   = stim[i][16];
    mem_rd_ena_i    = stim[i][17][0];
  endtask

  task automatic check_registered(input int i);
    check_val("valid_o", 64'(valid_o), 64'd1);
    check_val("class_o", 64'(class_o), expv[i][4]);
    check_val("funct3_o", 64'(funct3_o), expv[i][5]);
    check_val("alt_o", 64'(alt_o), expv[i][6]);
    check_val("op1_o", op1_o, expv[i][7]);
    check_val("op2_o", op2_o, expv[i][8]);
    check_val("rd_w_ena_o", 64'(rd_w_ena_o), expv[i][9]);
    check_val("rd_w_addr_o", 64'(rd_w_addr_o), expv[i][10]);
    check_val("pc_o", pc_o, stim[i][2]);
    check_val("mem_addr_o", mem_addr_o, expv[i][11]);
    check_val("mem_sel_o", 64'(mem_sel_o), expv[i][12]);
    check_val("jump_pc_ena_o", 64'(jump_pc_ena_o), expv[i][13]);
    if (expv[i][13] != 0) begin
      check_val("jump_pc_o", jump_pc_o, expv[i][14]);
    end
    check_val("pht_update_ena_o", 64'(pht_update_ena_o), expv[i][15]);
    if (expv[i][15] != 0) begin
      check_val("pht_index_o", 64'(pht_index_o), expv[i][16]);
      check_val("pht_taken_o", 64'(pht_taken_o), expv[i][17]);
    end
  endtask

  task automatic report_group(input int grp);
    $display("group %0d: %0d vectors, %0d errors", grp, grp_cnt, grp_errs);
    grp_cnt  = 0;
    grp_errs = 0;
  endtask

  // budget of 3 cycles per vector
  initial begin
    wait (n_vec > 0);
    #(n_vec * 3 * 20 + 200);
    $display("watchdog: the run did not finish in the expected time");
    $display("SOME TESTS FAILED");
    $finish;
  end

  initial begin
    clk_i           = 1'b0;
    arst_n_i        = 1'b0;
    inst_i          = '0;
    inst_valid_i    = 1'b0;
    pc_i            = '0;
    predict_taken_i = 1'b0;
    rs1_data_i      = '0;
    rs2_data_i      = '0;
    alu1_pc_i       = '0;
    alu1_rd_addr_i  = '0;
    alu1_rd_data_i  = '0;
    alu1_rd_ena_i   = 1'b0;
    alu2_pc_i       = '0;
    alu2_rd_addr_i  = '0;
    alu2_rd_data_i  = '0;
    alu2_rd_ena_i   = 1'b0;
    mem_pc_i        = '0;
    mem_rd_addr_i   = '0;
    mem_rd_data_i   = '0;
    mem_rd_ena_i    = 1'b0;
    n_vec           = 0;
    cur_vec         = -1;
    errors          = 0;
    grp_errs        = 0;
    grp_cnt         = 0;
    load_vectors();

    // behavior 1, reset and a bubble
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    check_idle_outputs();
    arst_n_i = 1'b1;
    @(negedge clk_i);
    check_idle_outputs();
    grp_cnt = 1;
    report_group(1);

    if (n_vec > 0) begin
      cur_grp = int'(stim[0][0]);
    end
    for (int i = 0; i < n_vec; i++) begin
      cur_vec = i;
      if (int'(stim[i][0]) != cur_grp) begin
        report_group(cur_grp);
        cur_grp = int'(stim[i][0]);
      end
      apply_vector(i);
      #1;
      check_val("rs1_addr_o", 64'(rs1_addr_o), expv[i][0]);
      check_val("rs1_read_o", 64'(rs1_read_o), expv[i][1]);
      check_val("rs2_addr_o", 64'(rs2_addr_o), expv[i][2]);
      check_val("rs2_read_o", 64'(rs2_read_o), expv[i][3]);
      @(posedge clk_i);
      @(negedge clk_i);
      check_registered(i);
      inst_valid_i = 1'b0;
      @(negedge clk_i);
      // enables drop after a bubble
      check_val("valid_o", 64'(valid_o), 64'd0);
      check_val("rd_w_ena_o", 64'(rd_w_ena_o), 64'd0);
      check_val("jump_pc_ena_o", 64'(jump_pc_ena_o), 64'd0);
      check_val("pht_update_ena_o", 64'(pht_update_ena_o), 64'd0);
      grp_cnt++;
    end
    if (n_vec > 0) begin
      report_group(cur_grp);
    end else begin
      $display("no test vectors were loaded");
      errors++;
    end

    $display("vectors run: %0d, failed checks: %0d", n_vec, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
